// File: source/agnus_pkg.sv
// agnus dma core shared types, register numbers, slot constants and bus structs
package agnus_pkg;

  // ------------------------------------------------------------
  // widths that carry a meaning
  typedef logic [15:0] data_word_t;  // register data bus word
  typedef logic [19:0] chip_addr_t;  // chip ram word address
  typedef logic [7:0]  reg_addr_t;   // custom register word number
  typedef logic [8:0]  hpos_t;       // horizontal slot position

  // ------------------------------------------------------------
  // custom register numbers (word index, not byte offset)
  localparam reg_addr_t REG_DMACON  = 8'h4B;  // dma control, write side
  localparam reg_addr_t REG_DMACONR = 8'h01;  // dma control, read side
  localparam reg_addr_t REG_IDLE    = 8'hFF;  // nothing selected on the register bus

  // slot timing
  localparam hpos_t LINE_LAST     = 9'd453;  // last slot of a line, then wrap
  localparam hpos_t REFRESH_FIRST = 9'd7;    // refresh window start
  localparam hpos_t REFRESH_LAST  = 9'd19;   // refresh window end

  // cpu starves for this many even slots and the blitter backs off
  localparam logic [1:0] BLS_CNT_MAX = 2'd3;

  // ------------------------------------------------------------
  // dma control register layout
  localparam int DMACON_WIDTH = 13;  // stored bits
  localparam int SETCLR_BIT   = 15;  // 1 sets, 0 clears the selected bits
  localparam int BLTPRI_BIT   = 10;  // blitter nasty
  localparam int DMAEN_BIT    = 9;   // master enable
  localparam int BPLEN_BIT    = 8;
  localparam int COPEN_BIT    = 7;
  localparam int BLTEN_BIT    = 6;
  localparam int SPREN_BIT    = 5;

  // one external dma requester, held until granted
  typedef struct packed {
    logic       req;          // wants the bus this slot
    logic       we;           // memory write (only honoured for disk and blitter)
    chip_addr_t address;      // chip ram address
    reg_addr_t  reg_address;  // destination / source custom register
  } chan_req_t;

  // cpu access to the custom register bank
  typedef struct packed {
    logic      aen;          // register bank selected
    logic      rd;
    logic      hwr;          // upper byte write
    logic      lwr;          // lower byte write
    reg_addr_t reg_address;
  } cpu_bus_t;

  // arbitrated bus towards memory and registers
  typedef struct packed {
    chip_addr_t address;
    reg_addr_t  reg_address;
    logic       dbr;         // chipset owns the data bus
    logic       dbwe;        // chipset memory write
    logic       cpu_custom;  // cpu owns the slot
  } chip_bus_t;

  // enables decoded from dmacon, each one already qualified by DMAEN
  typedef struct packed {
    logic bpl;
    logic spr;
    logic cop;
    logic blt;
    logic bltpri;  // raw, no master gating
  } dma_enables_t;

  // one-hot grant, highest priority first
  typedef struct packed {
    logic dsk;
    logic refr;  // refresh slot
    logic aud;
    logic bpl;
    logic spr;
    logic cop;
    logic blt;
    logic cpu;
  } dma_grant_t;

endpackage

// File: source/beam_slot_counter.sv
// horizontal slot counter for one line, with refresh slot decode
module beam_slot_counter (
  input  logic             clk,
  input  logic             reset,
  output agnus_pkg::hpos_t hpos,     // current slot
  output logic             refresh   // slot belongs to the refresh engine
);

  logic line_end;  // last slot of the line
  logic in_window; // inside the refresh range

  // ------------------------------------------------------------
  // slot counter

  assign line_end = (hpos == agnus_pkg::LINE_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
    end else if (line_end) begin
      hpos <= '0;                       // wrap to start of next line
    end else begin
      hpos <= hpos + agnus_pkg::hpos_t'(1);
    end
  end

  // ------------------------------------------------------------
  // refresh decode

  // window is inclusive at both ends
  assign in_window = (hpos >= agnus_pkg::REFRESH_FIRST) &&
                     (hpos <= agnus_pkg::REFRESH_LAST);

  // every fourth slot in the window, so 7, 11, 15, 19
  assign refresh = in_window && (hpos[1:0] == 2'b11);

endmodule

// File: source/dma_control_reg.sv
// dma control register with set/clear writes, read-back and channel enables
module dma_control_reg (
  input  logic                    clk,
  input  logic                    reset,
  input  agnus_pkg::reg_addr_t    reg_address,  // arbitrated register number
  input  agnus_pkg::data_word_t   data_in,
  input  logic                    blit_busy,    // blitter status, read-back only
  input  logic                    blit_zero,
  output agnus_pkg::data_word_t   data_out,
  output agnus_pkg::dma_enables_t enables
);

  logic [agnus_pkg::DMACON_WIDTH-1:0] dmacon;    // stored control bits
  logic [agnus_pkg::DMACON_WIDTH-1:0] wr_bits;   // bits selected by the write
  logic                               wr_hit;    // write cycle to dmacon
  logic                               rd_hit;    // dmaconr on the bus
  logic                               master_en; // DMAEN

  assign wr_hit  = (reg_address == agnus_pkg::REG_DMACON);
  assign rd_hit  = (reg_address == agnus_pkg::REG_DMACONR);
  assign wr_bits = data_in[agnus_pkg::DMACON_WIDTH-1:0];

  // ------------------------------------------------------------
  // register write

  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;
    end else if (wr_hit) begin
      if (data_in[agnus_pkg::SETCLR_BIT]) begin
        dmacon <= dmacon | wr_bits;   // set selected bits
      end else begin
        dmacon <= dmacon & ~wr_bits;  // clear selected bits
      end
    end
  end

  // ------------------------------------------------------------
  // read-back

  // bit 15 always reads zero, busy and zero sit above the stored bits
  assign data_out = rd_hit ? {1'b0, blit_busy, blit_zero, dmacon} : '0;

  // ------------------------------------------------------------
  // channel enables

  assign master_en = dmacon[agnus_pkg::DMAEN_BIT];

  assign enables.bpl    = dmacon[agnus_pkg::BPLEN_BIT] & master_en;
  assign enables.spr    = dmacon[agnus_pkg::SPREN_BIT] & master_en;
  assign enables.cop    = dmacon[agnus_pkg::COPEN_BIT] & master_en;
  assign enables.blt    = dmacon[agnus_pkg::BLTEN_BIT] & master_en;
  assign enables.bltpri = dmacon[agnus_pkg::BLTPRI_BIT]; // not gated by master

endmodule

// File: source/dma_arbiter.sv
// fixed priority slot arbiter, chip bus multiplexer and blitter slowdown counter
module dma_arbiter (
  input  logic                    clk,
  input  logic                    reset,
  input  agnus_pkg::chan_req_t    dsk_req,
  input  agnus_pkg::chan_req_t    aud_req,
  input  agnus_pkg::chan_req_t    bpl_req,
  input  agnus_pkg::chan_req_t    spr_req,
  input  agnus_pkg::chan_req_t    cop_req,
  input  agnus_pkg::chan_req_t    blt_req,
  input  agnus_pkg::cpu_bus_t     cpu,
  input  logic                    refresh,   // refresh slot from the counter
  input  agnus_pkg::hpos_t        hpos,
  input  logic                    bls,       // cpu is waiting for the bus
  input  agnus_pkg::dma_enables_t enables,
  output agnus_pkg::chip_bus_t    bus,
  output agnus_pkg::dma_grant_t   grant
);

  logic [1:0]           bls_cnt;   // even slots the cpu has missed
  logic                 blt_block; // blitter backs off for the cpu
  logic                 bpl_go;    // qualified requests
  logic                 spr_go;
  logic                 cop_go;
  logic                 blt_go;
  agnus_pkg::reg_addr_t cpu_reg;   // cpu register number or idle

  // bus image for a granted dma channel
  function automatic agnus_pkg::chip_bus_t chan_bus(input agnus_pkg::chan_req_t c,
                                                    input logic wr_ok);
    agnus_pkg::chip_bus_t b;
    b.address     = c.address;
    b.reg_address = c.reg_address;
    b.dbr         = 1'b1;
    b.dbwe        = c.we & wr_ok;  // only disk and blitter may write memory
    b.cpu_custom  = 1'b0;
    return b;
  endfunction

  // ------------------------------------------------------------
  // request qualification

  assign blt_block = (bls_cnt == agnus_pkg::BLS_CNT_MAX);

  assign bpl_go = bpl_req.req & enables.bpl;
  assign spr_go = spr_req.req & enables.spr;
  assign cop_go = cop_req.req & enables.cop;
  assign blt_go = blt_req.req & enables.blt & ~blt_block;

  // cpu only presents a register when it really accesses the bank
  assign cpu_reg = (cpu.aen & (cpu.rd | cpu.hwr | cpu.lwr)) ?
                   cpu.reg_address : agnus_pkg::REG_IDLE;

  // ------------------------------------------------------------
  // priority chain, first match wins

  always_comb begin
    grant = '0;
    bus   = '0;
    if (dsk_req.req) begin
      grant.dsk = 1'b1;
      bus       = chan_bus(dsk_req, 1'b1);
    end else if (refresh) begin
      grant.refr      = 1'b1;  // refresh cycle, no register target
      bus.reg_address = agnus_pkg::REG_IDLE;
      bus.dbr         = 1'b1;
    end else if (aud_req.req) begin
      grant.aud = 1'b1;
      bus       = chan_bus(aud_req, 1'b0);
    end else if (bpl_go) begin
      grant.bpl = 1'b1;
      bus       = chan_bus(bpl_req, 1'b0);
    end else if (spr_go) begin
      grant.spr = 1'b1;
      bus       = chan_bus(spr_req, 1'b0);
    end else if (cop_go) begin
      grant.cop = 1'b1;
      bus       = chan_bus(cop_req, 1'b0);
    end else if (blt_go) begin
      grant.blt = 1'b1;
      bus       = chan_bus(blt_req, 1'b1);
    end else begin
      grant.cpu       = 1'b1;   // slot left over for the cpu
      bus.reg_address = cpu_reg;
      bus.cpu_custom  = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // blitter slowdown, advanced on even slots only

  always_ff @(posedge clk) begin
    if (reset) begin
      bls_cnt <= '0;
    end else if (!hpos[0]) begin
      if (!bls || enables.bltpri) begin
        bls_cnt <= '0;              // cpu got through, or nasty mode
      end else if (!blt_block) begin
        bls_cnt <= bls_cnt + 2'd1;  // saturates at the limit
      end
    end
  end

endmodule

// File: source/agnus_dma.sv
// agnus dma core top: slot counter, dma control register and bus arbiter
module agnus_dma (
  input  logic                  clk,
  input  logic                  reset,
  input  agnus_pkg::chan_req_t  dsk_req,    // disk
  input  agnus_pkg::chan_req_t  aud_req,    // audio
  input  agnus_pkg::chan_req_t  bpl_req,    // bitplanes
  input  agnus_pkg::chan_req_t  spr_req,    // sprites
  input  agnus_pkg::chan_req_t  cop_req,    // copper
  input  agnus_pkg::chan_req_t  blt_req,    // blitter
  input  agnus_pkg::cpu_bus_t   cpu,
  input  agnus_pkg::data_word_t data_in,
  input  logic                  bls,        // cpu waiting for chip bus
  input  logic                  blit_busy,
  input  logic                  blit_zero,
  output agnus_pkg::chip_bus_t  bus,
  output agnus_pkg::dma_grant_t grant,
  output agnus_pkg::data_word_t data_out,
  output agnus_pkg::hpos_t      hpos
);

  logic                    refresh;  // refresh slot
  agnus_pkg::dma_enables_t enables;  // decoded dmacon

  // ------------------------------------------------------------
  // slot timing
  beam_slot_counter u_beam_slot_counter (
    .clk     (clk),
    .reset   (reset),
    .hpos    (hpos),
    .refresh (refresh)
  );

  // control register sees the arbitrated register bus
  dma_control_reg u_dma_control_reg (
    .clk         (clk),
    .reset       (reset),
    .reg_address (bus.reg_address),
    .data_in     (data_in),
    .blit_busy   (blit_busy),
    .blit_zero   (blit_zero),
    .data_out    (data_out),
    .enables     (enables)
  );

  // ------------------------------------------------------------
  // bus ownership
  dma_arbiter u_dma_arbiter (
    .clk     (clk),
    .reset   (reset),
    .dsk_req (dsk_req),
    .aud_req (aud_req),
    .bpl_req (bpl_req),
    .spr_req (spr_req),
    .cop_req (cop_req),
    .blt_req (blt_req),
    .cpu     (cpu),
    .refresh (refresh),
    .hpos    (hpos),
    .bls     (bls),
    .enables (enables),
    .bus     (bus),
    .grant   (grant)
  );

endmodule

// File: testbench/tb_agnus_dma.sv
// testbench for the agnus dma core, replays the case file against a model of dmacon
module tb_agnus_dma;

  localparam string CASE_FILE = "testbench/agnus_dma_cases.txt";

  logic                  clk;
  logic                  reset;
  agnus_pkg::chan_req_t  chan [6];  // dsk, aud, bpl, spr, cop, blt
  agnus_pkg::cpu_bus_t   cpu;
  agnus_pkg::data_word_t data_in;
  logic                  bls;
  logic                  blit_busy;
  logic                  blit_zero;
  agnus_pkg::chip_bus_t  bus;
  agnus_pkg::dma_grant_t grant;
  agnus_pkg::data_word_t data_out;
  agnus_pkg::hpos_t      hpos;
  agnus_pkg::hpos_t      hpos_ref;  // expected slot position

  logic [3:0]  op_q [$];    // one entry per case line
  int          slot_q [$];
  logic [15:0] arg1_q [$];
  logic [15:0] arg2_q [$];
  logic [15:0] exp_q [$];
  logic [12:0] model;       // expected dmacon contents
  logic [31:0] rng;
  int          errors;
  int          cycles;
  int          limit;

  agnus_dma u_agnus_dma (
    .clk (clk), .reset (reset),
    .dsk_req (chan[0]), .aud_req (chan[1]), .bpl_req (chan[2]),
    .spr_req (chan[3]), .cop_req (chan[4]), .blt_req (chan[5]),
    .cpu (cpu), .data_in (data_in), .bls (bls),
    .blit_busy (blit_busy), .blit_zero (blit_zero),
    .bus (bus), .grant (grant), .data_out (data_out), .hpos (hpos)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 unit period
  end

  // run guard, limit set once the case count is known
  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("error: timeout after %0d cycles, the case list never finished", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // slot position zero in reset, one step per clock, back to zero after the last slot
  always @(posedge clk) begin
    if (reset) begin
      hpos_ref = '0;
    end else if (hpos_ref == agnus_pkg::LINE_LAST) begin
      hpos_ref = '0;
    end else begin
      hpos_ref = hpos_ref + 9'd1;
    end
    #1;
    check_value(hpos, hpos_ref, "slot position");
  end

  task automatic next_slot();
    @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic wait_slot(input int target);
    while (hpos != agnus_pkg::hpos_t'(target)) begin
      next_slot();
    end
  endtask

  task automatic go_idle();
    for (int i = 0; i < 6; i++) begin
      chan[i] = '0;
    end
    cpu       = '0;
    data_in   = '0;
    blit_busy = 1'b0;
    blit_zero = 1'b0;
  endtask

  task automatic load_cases();
    int          fd;
    int          got;
    int          slot;
    string       line;
    logic [15:0] op;
    logic [15:0] a1;
    logic [15:0] a2;
    logic [15:0] ev;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("error: cannot open the case file %s", CASE_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin  // skip blanks and column notes
          got = $sscanf(line, "%h %d %h %h %h", op, slot, a1, a2, ev);
          if (got == 5) begin
            op_q.push_back(op[3:0]);
            slot_q.push_back(slot);
            arg1_q.push_back(a1);
            arg2_q.push_back(a2);
            exp_q.push_back(ev);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------
  // case operations

  task automatic dmacon_write(input logic [15:0] value);
    cpu.aen         = 1'b1;
    cpu.hwr         = 1'b1;
    cpu.lwr         = 1'b1;
    cpu.reg_address = agnus_pkg::REG_DMACON;
    data_in         = value;
    #2;
    check_value(grant, 32'h01, "cpu grant for dmacon write");
    next_slot();
    go_idle();
    if (value[15]) begin
      model = model | value[12:0];   // set
    end else begin
      model = model & ~value[12:0];  // clear
    end
  endtask

  task automatic reg_read(input logic [1:0] flags, input logic [15:0] exp_val);
    cpu.aen         = 1'b1;
    cpu.rd          = 1'b1;
    cpu.reg_address = agnus_pkg::REG_DMACONR;
    blit_busy       = flags[1];
    blit_zero       = flags[0];
    #2;
    check_value(data_out, exp_val, "dmaconr read");
    check_value(data_out, {1'b0, flags, model}, "dmaconr against model");
    check_value(grant, 32'h01, "cpu grant on read");
    check_value(bus.dbr, 1'b0, "dbr on cpu read");
    next_slot();
    go_idle();
  endtask

  // masks are dsk aud bpl spr cop blt from bit 5 down
  task automatic request_pattern(input logic [5:0] req, input logic [5:0] we,
                                 input logic [7:0] exp_grant);
    agnus_pkg::chip_bus_t exp_bus;
    for (int i = 0; i < 6; i++) begin
      rng                 = lcg_next(rng);
      chan[i].req         = req[5-i];
      chan[i].we          = we[5-i];
      chan[i].address     = rng[31:12];
      chan[i].reg_address = rng[7:0];
    end
    // refresh and an idle cpu both leave address 0 and no register
    exp_bus             = '0;
    exp_bus.reg_address = agnus_pkg::REG_IDLE;
    exp_bus.dbr         = ~exp_grant[0];
    exp_bus.cpu_custom  = exp_grant[0];
    for (int i = 0; i < 6; i++) begin
      if (exp_grant[(i == 0) ? 7 : 6 - i]) begin
        exp_bus.address     = chan[i].address;
        exp_bus.reg_address = chan[i].reg_address;
        exp_bus.dbwe        = chan[i].we && (i == 0 || i == 5);  // disk and blitter write
      end
    end
    #2;
    check_value(grant, exp_grant, "grant for request pattern");
    check_value(bus, exp_bus, "chip bus for request pattern");
    next_slot();
    go_idle();
  endtask

  task automatic bls_hold(input int n, input logic level, input logic exp_blt);
    bls         = level;  // stays after the case
    rng         = lcg_next(rng);
    chan[5].req = 1'b1;
    chan[5].address = rng[31:12];
    repeat (n) next_slot();
    #2;
    check_value(grant.blt, exp_blt, "blitter grant after bls hold");
    next_slot();
    go_idle();
  endtask

  // ------------------------------------------------------------
  // main sequence

  initial begin
    errors = 0;
    cycles = 0;
    limit  = 1000;
    model  = '0;
    rng    = 32'h2bf97235;
    reset  = 1'b1;
    bls    = 1'b0;
    go_idle();
    load_cases();
    limit = op_q.size() * (int'(agnus_pkg::LINE_LAST) + 1) + 100;
    if (op_q.size() == 0) begin
      errors++;
      $display("error: the case file holds no cases");
    end
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    for (int k = 0; k < op_q.size(); k++) begin
      wait_slot(slot_q[k]);
      case (op_q[k])
        4'h1: dmacon_write(arg1_q[k]);
        4'h2: reg_read(arg1_q[k][1:0], exp_q[k]);
        4'h3: request_pattern(arg1_q[k][5:0], arg2_q[k][5:0], exp_q[k][7:0]);
        4'h4: bls_hold(int'(arg1_q[k]), arg2_q[k][0], exp_q[k][0]);
        default: begin
          errors++;
          $display("error: case %0d has unknown operation %h", k, op_q[k]);
        end
      endcase
    end
    $display("cases run: %0d, errors: %0d", op_q.size(), errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: testbench/agnus_dma_chk.sv
// assertion checker for the agnus dma top, grant, bus ownership and slot range rules
module agnus_dma_chk (
  input logic                  clk,
  input logic                  reset,
  input agnus_pkg::chip_bus_t  bus,
  input agnus_pkg::dma_grant_t grant,
  input agnus_pkg::hpos_t      hpos
);

  // exactly one owner per slot
  grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(grant))
    else $error("grant is not one-hot");

  // chipset drives the data bus whenever the cpu is not granted
  dbr_vs_cpu: assert property (@(posedge clk) disable iff (reset) bus.dbr == !grant.cpu)
    else $error("dbr does not match the cpu grant");

  dbwe_owner: assert property (@(posedge clk) disable iff (reset)
                               bus.dbwe |-> (grant.dsk || grant.blt))
    else $error("memory write without a disk or blitter grant");

  hpos_range: assert property (@(posedge clk) disable iff (reset)
                               hpos <= agnus_pkg::LINE_LAST)
    else $error("hpos beyond the last slot of the line");

endmodule

bind agnus_dma agnus_dma_chk u_agnus_dma_chk (
  .clk   (clk),
  .reset (reset),
  .bus   (bus),
  .grant (grant),
  .hpos  (hpos)
);

// File: testbench/agnus_dma_cases.txt
# op hpos arg1 arg2 expect  (op 1 dmacon write arg1=data, 2 dmaconr read arg1=busy/zero)
# op 3 request arg1=req arg2=we expect=grant, op 4 bls hold arg1=cycles arg2=bls expect=blt
2 2 3 0 6000
1 3 83f0 0 0
2 5 0 0 03f0
1 6 0110 0 0
2 8 2 0 42e0
1 9 9101 0 0
2 10 1 0 33e1
1 12 1001 0 0
3 20 3f 3f 80
3 22 1f 1f 20
3 24 07 07 08
3 26 01 01 02
1 30 0100 0 0
3 32 0c 0 08
1 34 0200 0 0
3 36 0f 0f 01
1 38 8300 0 0
3 7 1f 0 40
3 11 3f 0 80
3 15 00 0 40
4 40 8 1 0
1 70 8400 0 0
4 74 2 1 1
1 80 0400 0 0
4 90 2 1 0
4 100 2 0 1
2 110 0 0 03e0

// File: build.f
source/agnus_pkg.sv
source/beam_slot_counter.sv
source/dma_control_reg.sv
source/dma_arbiter.sv
source/agnus_dma.sv
testbench/tb_agnus_dma.sv
testbench/agnus_dma_chk.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_agnus_dma
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
	  echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
